/* source/fabric_pkg.sv */
package fabric_pkg;

    // ----------------------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;

    // ----------------------------------------------------------------------
    // Address map, top nibble of the address
    // ----------------------------------------------------------------------
    localparam logic [3:0] SEG_TCM   = 4'h0;
    localparam logic [3:0] SEG_DEV   = 4'hC;
    localparam logic [3:0] SEG_CLINT = 4'hF;

    // TCM size, kept small for simulation
    localparam int TCM_WORDS = 1024;
    localparam int TCM_IDX_W = $clog2(TCM_WORDS);

    // Clock cycles per mtime increment
    localparam int CLINT_TICK_DIV = 4;

    // Decoded target of one access
    typedef enum logic [1:0] {
        REGION_TCM   = 2'd0,
        REGION_DEV   = 2'd1,
        REGION_CLINT = 2'd2,
        REGION_NONE  = 2'd3
    } region_e;

    // Word offsets inside the CLINT segment
    typedef enum logic [2:0] {
        CLINT_MSIP    = 3'd0,
        CLINT_CMP_LO  = 3'd1,
        CLINT_CMP_HI  = 3'd2,
        CLINT_TIME_LO = 3'd3,
        CLINT_TIME_HI = 3'd4
    } clint_reg_e;

    // ----------------------------------------------------------------------
    // Bus structs
    // ----------------------------------------------------------------------

    // One word access command
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        be_t   be;
        logic  we;
    } bus_cmd_t;

    // Target reply, done is a single-cycle pulse
    typedef struct packed {
        logic  done;
        data_t rdata;
    } tgt_rsp_t;

endpackage

/* source/bus_router.sv */
`timescale 1ns/1ps

module bus_router (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Master port, four-phase req/ack
    input  logic                cpu_req_i,
    input  fabric_pkg::bus_cmd_t cpu_cmd_i,
    output logic                cpu_ack_o,
    output fabric_pkg::data_t   cpu_rdata_o,

    // Target side, strobe and done pulse
    output fabric_pkg::bus_cmd_t tgt_cmd_o,
    output logic                tcm_stb_o,
    output logic                dev_stb_o,
    output logic                clint_stb_o,
    input  fabric_pkg::tgt_rsp_t tcm_rsp_i,
    input  fabric_pkg::tgt_rsp_t dev_rsp_i,
    input  fabric_pkg::tgt_rsp_t clint_rsp_i
);

    import fabric_pkg::*;

    // Handshake states
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        ACK
    } state_e;

    state_e   state_q;
    region_e  region_d;
    region_e  region_q;
    logic     stb_q;
    logic     ack_q;
    bus_cmd_t cmd_q;
    data_t    rdata_q;

    // Selected reply of the latched region
    logic     sel_done;
    data_t    sel_rdata;

    // ----------------------------------------------------------------------
    // Region decode on the top address nibble
    // ----------------------------------------------------------------------
    always_comb begin
        case (cpu_cmd_i.addr[ADDR_W-1 -: 4])
            SEG_TCM:   region_d = REGION_TCM;
            SEG_DEV:   region_d = REGION_DEV;
            SEG_CLINT: region_d = REGION_CLINT;
            // Former cached DRAM space falls here too
            default:   region_d = REGION_NONE;
        endcase
    end

    // Response mux driven by the region latched at the start of the access
    always_comb begin
        case (region_q)
            REGION_TCM: begin
                sel_done  = tcm_rsp_i.done;
                sel_rdata = tcm_rsp_i.rdata;
            end
            REGION_DEV: begin
                sel_done  = dev_rsp_i.done;
                sel_rdata = dev_rsp_i.rdata;
            end
            REGION_CLINT: begin
                sel_done  = clint_rsp_i.done;
                sel_rdata = clint_rsp_i.rdata;
            end
            default: begin
                // Unmapped, complete at once with zero
                sel_done  = 1'b1;
                sel_rdata = '0;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Handshake FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            region_q <= REGION_NONE;
            stb_q    <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            // Strobe lasts a single cycle
            stb_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (cpu_req_i) begin
                        region_q <= region_d;
                        stb_q    <= (region_d != REGION_NONE);
                        state_q  <= WAIT;
                    end
                end
                WAIT: begin
                    // Ack one cycle after the target's done
                    if (sel_done) begin
                        ack_q   <= 1'b1;
                        state_q <= ACK;
                    end
                end
                ACK: begin
                    // Hold ack until the master lets go of req
                    if (!cpu_req_i) begin
                        ack_q   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Command and read data registers
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && cpu_req_i) begin
            cmd_q <= cpu_cmd_i;
        end
        if (state_q == WAIT && sel_done) begin
            rdata_q <= sel_rdata;
        end
    end

    assign tgt_cmd_o   = cmd_q;
    assign tcm_stb_o   = stb_q && (region_q == REGION_TCM);
    assign dev_stb_o   = stb_q && (region_q == REGION_DEV);
    assign clint_stb_o = stb_q && (region_q == REGION_CLINT);
    assign cpu_ack_o   = ack_q;
    assign cpu_rdata_o = rdata_q;

endmodule

/* source/tcm_sram.sv */
`timescale 1ns/1ps

module tcm_sram (
    input  logic                 clk_i,
    input  logic                 stb_i,
    input  fabric_pkg::bus_cmd_t cmd_i,
    output fabric_pkg::tgt_rsp_t rsp_o
);

    import fabric_pkg::*;

    // Word storage, contents undefined after power-up
    data_t mem [TCM_WORDS];

    logic [TCM_IDX_W-1:0] idx;
    logic                 done_q;
    data_t                rdata_q;

    // Word index, byte offset bits dropped
    assign idx = cmd_i.addr[TCM_IDX_W+1:2];

    // ----------------------------------------------------------------------
    // Synchronous access port
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (stb_i && cmd_i.we) begin
            // Update only the enabled byte lanes
            for (int b = 0; b < BE_W; b++) begin
                if (cmd_i.be[b]) begin
                    mem[idx][b*8 +: 8] <= cmd_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        // Done follows the strobe by one cycle
        done_q <= stb_i;
        if (stb_i) begin
            if (cmd_i.we) begin
                // Writes answer with zero
                rdata_q <= '0;
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    assign rsp_o.done  = done_q;
    assign rsp_o.rdata = rdata_q;

endmodule

/* source/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 stb_i,
    input  fabric_pkg::bus_cmd_t cmd_i,
    output fabric_pkg::tgt_rsp_t rsp_o,
    output logic                 tmr_irq_o,
    output logic                 sft_irq_o
);

    import fabric_pkg::*;

    logic [$clog2(CLINT_TICK_DIV)-1:0] presc_q;
    logic        tick;
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        msip_q;
    logic        tmr_irq_q;
    logic        done_q;
    data_t       rdata_q;

    // Register select
    clint_reg_e  reg_sel;
    logic        reg_hit;
    logic        wr_en;
    data_t       rd_word;

    // Offsets above the register block are unknown
    assign reg_sel = clint_reg_e'(cmd_i.addr[4:2]);
    assign reg_hit = (cmd_i.addr[ADDR_W-5:5] == '0);
    assign wr_en   = stb_i && cmd_i.we && reg_hit;

    // ----------------------------------------------------------------------
    // Prescaler and mtime
    // ----------------------------------------------------------------------
    assign tick = (presc_q == CLINT_TICK_DIV - 1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            presc_q <= '0;
            mtime_q <= '0;
        end else begin
            if (tick) begin
                presc_q <= '0;
                mtime_q <= mtime_q + 64'd1;
            end else begin
                presc_q <= presc_q + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Writable registers and interrupt
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // All ones keeps the timer interrupt quiet
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
            tmr_irq_q  <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q    <= stb_i;
            tmr_irq_q <= (mtime_q >= mtimecmp_q);
            if (wr_en) begin
                case (reg_sel)
                    CLINT_MSIP:   msip_q            <= cmd_i.wdata[0];
                    CLINT_CMP_LO: mtimecmp_q[31:0]  <= cmd_i.wdata;
                    CLINT_CMP_HI: mtimecmp_q[63:32] <= cmd_i.wdata;
                    // mtime is read-only here
                    default: ;
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        rd_word = '0;
        if (reg_hit) begin
            case (reg_sel)
                CLINT_MSIP:    rd_word = {{(DATA_W-1){1'b0}}, msip_q};
                CLINT_CMP_LO:  rd_word = mtimecmp_q[31:0];
                CLINT_CMP_HI:  rd_word = mtimecmp_q[63:32];
                CLINT_TIME_LO: rd_word = mtime_q[31:0];
                CLINT_TIME_HI: rd_word = mtime_q[63:32];
                default:       rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (stb_i) begin
            rdata_q <= cmd_i.we ? '0 : rd_word;
        end
    end

    assign rsp_o.done  = done_q;
    assign rsp_o.rdata = rdata_q;
    assign tmr_irq_o   = tmr_irq_q;
    assign sft_irq_o   = msip_q;

endmodule

/* source/dev_bridge.sv */
`timescale 1ns/1ps

module dev_bridge (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // From the router
    input  logic                 stb_i,
    input  fabric_pkg::bus_cmd_t cmd_i,
    output fabric_pkg::tgt_rsp_t rsp_o,

    // External device port, four-phase req/ack
    output logic                 dev_req_o,
    output fabric_pkg::bus_cmd_t dev_cmd_o,
    input  logic                 dev_ack_i,
    input  fabric_pkg::data_t    dev_rdata_i
);

    import fabric_pkg::*;

    // Exchange phases
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } state_e;

    state_e   state_q;
    logic     req_q;
    logic     done_q;
    bus_cmd_t cmd_q;
    data_t    rdata_q;

    // ----------------------------------------------------------------------
    // Four-phase sequencer
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            req_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (stb_i) begin
                        req_q   <= 1'b1;
                        state_q <= REQ;
                    end
                end
                REQ: begin
                    // Device answered, release req
                    if (dev_ack_i) begin
                        req_q   <= 1'b0;
                        state_q <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Answer the router only after ack has fallen
                    if (!dev_ack_i) begin
                        done_q  <= 1'b1;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Command held stable for the whole exchange
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && stb_i) begin
            cmd_q <= cmd_i;
        end
        // Sample read data on the first cycle ack is seen
        if (state_q == REQ && dev_ack_i) begin
            rdata_q <= dev_rdata_i;
        end
    end

    assign dev_req_o   = req_q;
    assign dev_cmd_o   = cmd_q;
    assign rsp_o.done  = done_q;
    assign rsp_o.rdata = rdata_q;

endmodule

/* source/mem_fabric_top.sv */
`timescale 1ns/1ps

module mem_fabric_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Master data port
    input  logic                 cpu_req_i,
    input  fabric_pkg::bus_cmd_t cpu_cmd_i,
    output logic                 cpu_ack_o,
    output fabric_pkg::data_t    cpu_rdata_o,

    // Uncached device port
    output logic                 dev_req_o,
    output fabric_pkg::bus_cmd_t dev_cmd_o,
    input  logic                 dev_ack_i,
    input  fabric_pkg::data_t    dev_rdata_i,

    // Core-local interrupts
    output logic                 tmr_irq_o,
    output logic                 sft_irq_o
);

    import fabric_pkg::*;

    // ----------------------------------------------------------------------
    // Router to target wiring
    // ----------------------------------------------------------------------
    bus_cmd_t tgt_cmd;
    logic     tcm_stb;
    logic     dev_stb;
    logic     clint_stb;
    tgt_rsp_t tcm_rsp;
    tgt_rsp_t dev_rsp;
    tgt_rsp_t clint_rsp;

    // Decode and handshake
    bus_router u_router (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_cmd_i   (cpu_cmd_i),
        .cpu_ack_o   (cpu_ack_o),
        .cpu_rdata_o (cpu_rdata_o),
        .tgt_cmd_o   (tgt_cmd),
        .tcm_stb_o   (tcm_stb),
        .dev_stb_o   (dev_stb),
        .clint_stb_o (clint_stb),
        .tcm_rsp_i   (tcm_rsp),
        .dev_rsp_i   (dev_rsp),
        .clint_rsp_i (clint_rsp)
    );

    // Segment 0x0
    tcm_sram u_tcm (
        .clk_i (clk_i),
        .stb_i (tcm_stb),
        .cmd_i (tgt_cmd),
        .rsp_o (tcm_rsp)
    );

    // Segment 0xC
    dev_bridge u_dev (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .stb_i       (dev_stb),
        .cmd_i       (tgt_cmd),
        .rsp_o       (dev_rsp),
        .dev_req_o   (dev_req_o),
        .dev_cmd_o   (dev_cmd_o),
        .dev_ack_i   (dev_ack_i),
        .dev_rdata_i (dev_rdata_i)
    );

    // Segment 0xF
    clint_timer u_clint (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .stb_i     (clint_stb),
        .cmd_i     (tgt_cmd),
        .rsp_o     (clint_rsp),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

endmodule

/* test/tb_mem_fabric.sv */
`timescale 1ns/1ps

module tb_mem_fabric;

    import fabric_pkg::*;

    // ----------------------------------------------------------------------
    // Test parameters
    // ----------------------------------------------------------------------
    localparam int          CLK_HALF     = 20;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] SEED         = 32'h63850381;
    localparam int          TCM_TESTS    = 64;
    localparam int          DEV_TESTS    = 32;
    // About 300 accesses of up to 30 cycles, doubled, plus the timer wait
    localparam int          MAX_XFERS      = 300;
    localparam int          XFER_CYCLES    = 30;
    localparam int          TIMER_WAIT     = 2000;
    localparam int          TIMEOUT_CYCLES = 2 * MAX_XFERS * XFER_CYCLES + TIMER_WAIT;

    logic     clk_i;
    logic     rst_n_i;
    logic     cpu_req_i;
    bus_cmd_t cpu_cmd_i;
    logic     cpu_ack_o;
    data_t    cpu_rdata_o;
    logic     dev_req_o;
    bus_cmd_t dev_cmd_o;
    logic     dev_ack_i;
    data_t    dev_rdata_i;
    logic     tmr_irq_o;
    logic     sft_irq_o;

    int          err_count   = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] rnd_q;
    logic [31:0] dev_rnd_q;

    // What the device model saw and returned on its last exchange
    bus_cmd_t dev_seen_cmd;
    data_t    dev_sent_data;
    int       dev_xfer_count;

    // Expected TCM contents and the word indices under test
    data_t                tcm_model [TCM_WORDS];
    logic [TCM_IDX_W-1:0] tcm_idx   [TCM_TESTS];

    mem_fabric_top uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_cmd_i   (cpu_cmd_i),
        .cpu_ack_o   (cpu_ack_o),
        .cpu_rdata_o (cpu_rdata_o),
        .dev_req_o   (dev_req_o),
        .dev_cmd_o   (dev_cmd_o),
        .dev_ack_i   (dev_ack_i),
        .dev_rdata_i (dev_rdata_i),
        .tmr_irq_o   (tmr_irq_o),
        .sft_irq_o   (sft_irq_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #CLK_HALF clk_i = ~clk_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        rnd_q = lcg_next(rnd_q);
        return rnd_q;
    endfunction

    function automatic addr_t tcm_addr(input logic [TCM_IDX_W-1:0] idx);
        return {SEG_TCM, 16'h0, idx, 2'b00};
    endfunction

    function automatic addr_t clint_addr(input clint_reg_e off);
        return {SEG_CLINT, 23'h0, off, 2'b00};
    endfunction

    // Inputs change 2 ns after the rising edge, outputs are read there too
    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    // ----------------------------------------------------------------------
    // Device responder on the external port
    // ----------------------------------------------------------------------
    initial begin
        int delay;
        dev_ack_i      = 1'b0;
        dev_rdata_i    = '0;
        dev_xfer_count = 0;
        dev_rnd_q      = lcg_next(SEED);
        forever begin
            step();
            if (dev_req_o) begin
                dev_rnd_q = lcg_next(dev_rnd_q);
                delay     = int'(dev_rnd_q[18:16]) % 6;
                repeat (delay) step();
                dev_seen_cmd  = dev_cmd_o;
                dev_rnd_q     = lcg_next(dev_rnd_q);
                dev_sent_data = dev_cmd_o.we ? '0 : dev_rnd_q;
                dev_rdata_i   = dev_sent_data;
                dev_ack_i     = 1'b1;
                dev_xfer_count++;
                // Hold ack until the bridge lets go of req
                while (dev_req_o) step();
                dev_ack_i = 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Master port tasks
    // ----------------------------------------------------------------------
    task automatic bus_access(input bus_cmd_t cmd, output data_t rdata);
        cpu_cmd_i = cmd;
        cpu_req_i = 1'b1;
        do step(); while (!cpu_ack_o);
        rdata     = cpu_rdata_o;
        cpu_req_i = 1'b0;
        // Next request only once ack is low again
        do step(); while (cpu_ack_o);
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata, input be_t be);
        bus_cmd_t cmd;
        data_t    unused;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd.be    = be;
        cmd.we    = 1'b1;
        bus_access(cmd, unused);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        bus_cmd_t cmd;
        cmd.addr  = addr;
        cmd.wdata = '0;
        cmd.be    = '1;
        cmd.we    = 1'b0;
        bus_access(cmd, rdata);
    endtask

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic check_data(input data_t actual, input data_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("Fail at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    task automatic check_cmd(input bus_cmd_t actual, input bus_cmd_t expected,
                             input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("Fail at %0t ns: %s, expected addr %h wdata %h be %h we %b", $time, what,
                     expected.addr, expected.wdata, expected.be, expected.we);
            $display("    got addr %h wdata %h be %h we %b",
                     actual.addr, actual.wdata, actual.be, actual.we);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("Fail at %0t ns: %s, expected %b, got %b", $time, what, expected, actual);
        end
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_reset();
        check_bit(cpu_ack_o, 1'b0, "cpu_ack_o after reset");
        check_bit(dev_req_o, 1'b0, "dev_req_o after reset");
        check_bit(tmr_irq_o, 1'b0, "tmr_irq_o after reset");
        check_bit(sft_irq_o, 1'b0, "sft_irq_o after reset");
    endtask

    task automatic test_tcm();
        logic [31:0]          r;
        data_t                wdata;
        data_t                got;
        be_t                  be;
        logic [TCM_IDX_W-1:0] idx;
        // Full-word writes give every tested word a known value
        for (int i = 0; i < TCM_TESTS; i++) begin
            r          = rand_word();
            tcm_idx[i] = r[TCM_IDX_W+11:12];
            wdata      = rand_word();
            tcm_model[tcm_idx[i]] = wdata;
            bus_write(tcm_addr(tcm_idx[i]), wdata, 4'hF);
        end
        // Partial writes replace only the enabled bytes
        for (int i = 0; i < TCM_TESTS; i++) begin
            r     = rand_word();
            idx   = tcm_idx[int'(r[31:26])];
            be    = r[23:20];
            wdata = rand_word();
            for (int b = 0; b < BE_W; b++) begin
                if (be[b]) begin
                    tcm_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            bus_write(tcm_addr(idx), wdata, be);
        end
        for (int i = 0; i < TCM_TESTS; i++) begin
            bus_read(tcm_addr(tcm_idx[i]), got);
            check_data(got, tcm_model[tcm_idx[i]], "TCM read back");
        end
    endtask

    task automatic test_dev();
        logic [31:0] r;
        bus_cmd_t    cmd;
        data_t       got;
        int          count_before;
        for (int i = 0; i < DEV_TESTS; i++) begin
            r         = rand_word();
            cmd.addr  = {SEG_DEV, r[31:6], 2'b00};
            r         = rand_word();
            cmd.be    = r[27:24];
            cmd.we    = r[31];
            cmd.wdata = rand_word();
            count_before = dev_xfer_count;
            bus_access(cmd, got);
            check_bit(dev_xfer_count == count_before + 1, 1'b1, "one device exchange");
            check_cmd(dev_seen_cmd, cmd, "command at device port");
            if (!cmd.we) begin
                check_data(got, dev_sent_data, "device read data");
            end
        end
    endtask

    task automatic test_msip();
        data_t got;
        bus_write(clint_addr(CLINT_MSIP), 32'd1, 4'hF);
        check_bit(sft_irq_o, 1'b1, "sft_irq_o after msip set");
        bus_read(clint_addr(CLINT_MSIP), got);
        check_data(got, 32'd1, "msip read back");
        bus_write(clint_addr(CLINT_MSIP), 32'd0, 4'hF);
        check_bit(sft_irq_o, 1'b0, "sft_irq_o after msip clear");
    endtask

    task automatic test_timer();
        data_t       lo;
        data_t       hi;
        logic [63:0] t1;
        logic [63:0] t2;
        logic [63:0] cmp;
        int          waited;
        bus_read(clint_addr(CLINT_TIME_LO), lo);
        bus_read(clint_addr(CLINT_TIME_HI), hi);
        t1 = {hi, lo};
        repeat (40) step();
        bus_read(clint_addr(CLINT_TIME_LO), lo);
        bus_read(clint_addr(CLINT_TIME_HI), hi);
        t2 = {hi, lo};
        check_bit(t2 > t1, 1'b1, "mtime advances");
        // Low half first, so the compare never drops below mtime early
        cmp = t2 + 64'd16;
        bus_write(clint_addr(CLINT_CMP_LO), cmp[31:0], 4'hF);
        bus_write(clint_addr(CLINT_CMP_HI), cmp[63:32], 4'hF);
        waited = 0;
        while (!tmr_irq_o && waited < 200) begin
            step();
            waited++;
        end
        check_bit(tmr_irq_o, 1'b1, "tmr_irq_o within 200 cycles");
        bus_write(clint_addr(CLINT_CMP_LO), 32'hFFFF_FFFF, 4'hF);
        bus_write(clint_addr(CLINT_CMP_HI), 32'hFFFF_FFFF, 4'hF);
        step();
        check_bit(tmr_irq_o, 1'b0, "tmr_irq_o after compare reset");
    endtask

    task automatic test_unmapped();
        data_t got;
        bus_write(32'h8000_0010, 32'hA5A5_5A5A, 4'hF);
        bus_read(32'h8000_0010, got);
        check_data(got, 32'h0, "unmapped read");
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst_n_i   = 1'b0;
        cpu_req_i = 1'b0;
        cpu_cmd_i = '0;
        rnd_q     = SEED;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        step();
        test_reset();
        test_tcm();
        test_dev();
        test_msip();
        test_timer();
        test_unmapped();
        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/fabric_pkg.sv
source/bus_router.sv
source/tcm_sram.sv
source/clint_timer.sv
source/dev_bridge.sv
source/mem_fabric_top.sv
test/tb_mem_fabric.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_mem_fabric \
    -f verilog.f -o tb_mem_fabric &&
./obj_dir/tb_mem_fabric | tee /dev/stderr | grep -q -F -e '** PASS **' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
